// ==== flist.f ====
src/cpu_pkg.sv
src/id_type_i.sv
src/id_type_r.sv
src/regfile.sv
src/cpu_id.sv
src/id_ex_reg.sv
src/cpu_id_top.sv
verif/tb_cpu_id.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_cpu_id -f flist.f -o sim_tb_cpu_id

./obj_dir/sim_tb_cpu_id > sim.log 2>&1 || true
cat sim.log

# the pass line decides the result
grep -q "^Testbench passed$" sim.log
echo "simulation passed"

// ==== src/cpu_id.sv ====
`default_nettype none

module cpu_id (
	input  wire cpu_pkg::inst_addr_t      pc_i,
	input  wire cpu_pkg::inst_t           inst_i,
	input  wire logic                     delayslot_i,
	input  wire cpu_pkg::word_t           reg1_i,
	input  wire cpu_pkg::word_t           reg2_i,
	output cpu_pkg::reg_addr_t            reg_raddr1_o,
	output cpu_pkg::reg_addr_t            reg_raddr2_o,
	input  wire cpu_pkg::mem_access_req_t ex_mem_req_i,
	input  wire cpu_pkg::reg_write_req_t  ex_wr_i,
	input  wire cpu_pkg::reg_write_req_t  mem_wr_i,
	output cpu_pkg::pipeline_data_t       data_id_o,
	output logic                          stall_req_o
);

	logic [5:0] opcode;
	cpu_pkg::half_word_t immediate;
	cpu_pkg::word_t imm_zero_ext, imm_sign_ext, imm;
	cpu_pkg::word_t safe_reg1, safe_reg2;
	cpu_pkg::oper_e op, op_type_i, op_type_j, op_type_r;
	cpu_pkg::reg_addr_t raddr1_type_i, raddr2_type_i, waddr_type_i;
	cpu_pkg::reg_addr_t raddr1_type_r, raddr2_type_r, waddr_type_r;
	cpu_pkg::reg_addr_t reg_waddr;
	logic we_type_i, we_type_r, unsigned_imm;
	logic dec_we, imm_to_reg2, cond_move_not_taken, ex_is_load;

	// newest in-flight value wins, register 0 never forwards
	function automatic cpu_pkg::word_t forward(
		input cpu_pkg::reg_addr_t     raddr,
		input cpu_pkg::word_t         rf_data,
		input cpu_pkg::reg_write_req_t ex_wr,
		input cpu_pkg::reg_write_req_t mem_wr
	);
		cpu_pkg::word_t data;
		if (raddr == 5'd0) begin
			data = cpu_pkg::ZERO_WORD;
		end else if (ex_wr.we && ex_wr.waddr == raddr) begin
			data = ex_wr.wdata;
		end else if (mem_wr.we && mem_wr.waddr == raddr) begin
			data = mem_wr.wdata;
		end else begin
			data = rf_data;
		end
		return data;
	endfunction

	assign opcode       = inst_i[31:26];
	assign immediate    = inst_i[15:0];
	assign imm_zero_ext = {16'h0, immediate};
	assign imm_sign_ext = {{16{immediate[15]}}, immediate};

	id_type_i i_id_type_i (
		.opcode_i       (opcode),
		.inst_i         (inst_i),
		.op_o           (op_type_i),
		.reg_raddr1_o   (raddr1_type_i),
		.reg_raddr2_o   (raddr2_type_i),
		.reg_waddr_o    (waddr_type_i),
		.reg_we_o       (we_type_i),
		.unsigned_imm_o (unsigned_imm)
	);

	id_type_r i_id_type_r (
		.opcode_i     (opcode),
		.inst_i       (inst_i),
		.op_o         (op_type_r),
		.reg_raddr1_o (raddr1_type_r),
		.reg_raddr2_o (raddr2_type_r),
		.reg_waddr_o  (waddr_type_r),
		.reg_we_o     (we_type_r)
	);

	// only two jumps, small enough to decode here
	always_comb begin
		case (opcode)
			cpu_pkg::OPC_J:   op_type_j = cpu_pkg::OP_J;
			cpu_pkg::OPC_JAL: op_type_j = cpu_pkg::OP_JAL;
			default:          op_type_j = cpu_pkg::OP_INVALID;
		endcase
	end

	// format priority: I, J, R
	always_comb begin
		op           = cpu_pkg::OP_INVALID;
		reg_raddr1_o = 5'd0;
		reg_raddr2_o = 5'd0;
		reg_waddr    = 5'd0;
		dec_we       = 1'b0;
		imm          = cpu_pkg::ZERO_WORD;
		imm_to_reg2  = 1'b0;

		if (op_type_i != cpu_pkg::OP_INVALID) begin
			op           = op_type_i;
			reg_raddr1_o = raddr1_type_i;
			reg_raddr2_o = raddr2_type_i;
			reg_waddr    = waddr_type_i;
			dec_we       = we_type_i;
			imm          = unsigned_imm ? imm_zero_ext : imm_sign_ext;
			// stores and two-register branches need rt in reg2
			imm_to_reg2  = !(opcode == cpu_pkg::OPC_SW || opcode == cpu_pkg::OPC_BEQ ||
			                 opcode == cpu_pkg::OPC_BNE);
		end else if (op_type_j != cpu_pkg::OP_INVALID) begin
			op = op_type_j;
			if (op_type_j == cpu_pkg::OP_JAL) begin
				reg_waddr = cpu_pkg::REG_RA;
				dec_we    = 1'b1;
			end
		end else if (op_type_r != cpu_pkg::OP_INVALID) begin
			op           = op_type_r;
			reg_raddr1_o = raddr1_type_r;
			reg_raddr2_o = raddr2_type_r;
			reg_waddr    = waddr_type_r;
			dec_we       = we_type_r;
		end
	end

	assign safe_reg1 = forward(reg_raddr1_o, reg1_i, ex_wr_i, mem_wr_i);
	assign safe_reg2 = forward(reg_raddr2_o, reg2_i, ex_wr_i, mem_wr_i);

	// movn/movz drop the write when the condition fails
	assign cond_move_not_taken =
		(op == cpu_pkg::OP_MOVN && safe_reg2 == cpu_pkg::ZERO_WORD) ||
		(op == cpu_pkg::OP_MOVZ && safe_reg2 != cpu_pkg::ZERO_WORD);

	// load result is not ready until MEM
	assign ex_is_load  = ex_mem_req_i.ce && !ex_mem_req_i.we;
	assign stall_req_o = ex_is_load &&
		((reg_raddr1_o != 5'd0 && ex_wr_i.waddr == reg_raddr1_o) ||
		 (reg_raddr2_o != 5'd0 && ex_wr_i.waddr == reg_raddr2_o));

	assign data_id_o.op         = op;
	assign data_id_o.pc         = pc_i;
	assign data_id_o.inst       = inst_i;
	assign data_id_o.reg1       = safe_reg1;
	assign data_id_o.reg2       = imm_to_reg2 ? imm : safe_reg2;
	assign data_id_o.imm        = imm;
	assign data_id_o.reg_raddr1 = reg_raddr1_o;
	assign data_id_o.reg_raddr2 = reg_raddr2_o;
	assign data_id_o.reg_we     = dec_we && !cond_move_not_taken;
	assign data_id_o.reg_waddr  = reg_waddr;
	assign data_id_o.delayslot  = delayslot_i;

endmodule

`default_nettype wire

// ==== src/cpu_id_top.sv ====
`default_nettype none

module cpu_id_top (
	input  wire logic                     clk_i,
	input  wire logic                     rst_n_i,
	input  wire cpu_pkg::inst_addr_t      pc_i,
	input  wire cpu_pkg::inst_t           inst_i,
	input  wire logic                     delayslot_i,
	input  wire cpu_pkg::mem_access_req_t ex_mem_req_i,
	input  wire cpu_pkg::reg_write_req_t  ex_wr_i,
	input  wire cpu_pkg::reg_write_req_t  mem_wr_i,
	input  wire cpu_pkg::reg_write_req_t  wb_wr_i,
	output cpu_pkg::pipeline_data_t       id_ex_o,
	output logic                          id_ex_valid_o,
	output logic                          stall_o
);

	cpu_pkg::reg_addr_t reg_raddr1, reg_raddr2;
	cpu_pkg::word_t reg1, reg2;
	cpu_pkg::pipeline_data_t data_id;
	logic stall_req;

	regfile i_regfile (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.raddr1_i (reg_raddr1),
		.raddr2_i (reg_raddr2),
		.rdata1_o (reg1),
		.rdata2_o (reg2),
		.wr_i     (wb_wr_i)
	);

	cpu_id i_cpu_id (
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.delayslot_i  (delayslot_i),
		.reg1_i       (reg1),
		.reg2_i       (reg2),
		.reg_raddr1_o (reg_raddr1),
		.reg_raddr2_o (reg_raddr2),
		.ex_mem_req_i (ex_mem_req_i),
		.ex_wr_i      (ex_wr_i),
		.mem_wr_i     (mem_wr_i),
		.data_id_o    (data_id),
		.stall_req_o  (stall_req)
	);

	id_ex_reg i_id_ex_reg (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.stall_i (stall_req),
		.data_i  (data_id),
		.data_o  (id_ex_o),
		.valid_o (id_ex_valid_o)
	);

	// fetch holds its instruction while this is high
	assign stall_o = stall_req;

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// basic word types
	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [31:0] inst_addr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] half_word_t;

	localparam word_t     ZERO_WORD = 32'h0;
	// link register for jal
	localparam reg_addr_t REG_RA    = 5'd31;

	// op 0 doubles as the bubble, so a cleared bundle is invalid
	// immediate ALU forms share the op of their register forms
	typedef enum logic [5:0] {
		OP_INVALID = 6'd0,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_SLT,
		OP_SLTU,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_LUI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_BLTZ,
		OP_BGEZ,
		OP_J,
		OP_JAL,
		OP_JR,
		OP_MOVZ,
		OP_MOVN
	} oper_e;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_write_req_t;

	// ce without we is a load
	typedef struct packed {
		logic ce;
		logic we;
	} mem_access_req_t;

	typedef struct packed {
		oper_e      op;
		inst_addr_t pc;
		inst_t      inst;
		word_t      reg1;
		word_t      reg2;
		word_t      imm;
		reg_addr_t  reg_raddr1;
		reg_addr_t  reg_raddr2;
		logic       reg_we;
		reg_addr_t  reg_waddr;
		logic       delayslot;
	} pipeline_data_t;

	// primary opcodes
	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_REGIMM  = 6'b000001;
	localparam logic [5:0] OPC_J       = 6'b000010;
	localparam logic [5:0] OPC_JAL     = 6'b000011;
	localparam logic [5:0] OPC_BEQ     = 6'b000100;
	localparam logic [5:0] OPC_BNE     = 6'b000101;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_SLTI    = 6'b001010;
	localparam logic [5:0] OPC_SLTIU   = 6'b001011;
	localparam logic [5:0] OPC_ANDI    = 6'b001100;
	localparam logic [5:0] OPC_ORI     = 6'b001101;
	localparam logic [5:0] OPC_XORI    = 6'b001110;
	localparam logic [5:0] OPC_LUI     = 6'b001111;
	localparam logic [5:0] OPC_LW      = 6'b100011;
	localparam logic [5:0] OPC_SW      = 6'b101011;

	// regimm selectors in the rt field
	localparam reg_addr_t RT_BLTZ = 5'b00000;
	localparam reg_addr_t RT_BGEZ = 5'b00001;

	// special funct codes
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_MOVZ = 6'b001010;
	localparam logic [5:0] FN_MOVN = 6'b001011;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

endpackage

`default_nettype wire

// ==== src/id_ex_reg.sv ====
`default_nettype none

module id_ex_reg (
	input  wire logic                    clk_i,
	input  wire logic                    rst_n_i,
	input  wire logic                    stall_i,
	input  wire cpu_pkg::pipeline_data_t data_i,
	output cpu_pkg::pipeline_data_t      data_o,
	output logic                         valid_o
);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			data_o  <= '0;
			valid_o <= 1'b0;
		end else if (stall_i) begin
			// held instruction stays in ID while EX gets a cleared bundle
			data_o  <= '0;
			valid_o <= 1'b0;
		end else begin
			data_o  <= data_i;
			valid_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/id_type_i.sv ====
`default_nettype none

module id_type_i (
	input  wire logic [5:0]         opcode_i,
	input  wire cpu_pkg::inst_t     inst_i,
	output cpu_pkg::oper_e          op_o,
	output cpu_pkg::reg_addr_t      reg_raddr1_o,
	output cpu_pkg::reg_addr_t      reg_raddr2_o,
	output cpu_pkg::reg_addr_t      reg_waddr_o,
	output logic                    reg_we_o,
	output logic                    unsigned_imm_o
);

	cpu_pkg::reg_addr_t rs, rt;

	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];

	always_comb begin
		// ALU immediate form by default: rs in, rt out
		op_o           = cpu_pkg::OP_INVALID;
		reg_raddr1_o   = rs;
		reg_raddr2_o   = 5'd0;
		reg_waddr_o    = rt;
		reg_we_o       = 1'b1;
		unsigned_imm_o = 1'b0;

		case (opcode_i)
			cpu_pkg::OPC_ADDIU: op_o = cpu_pkg::OP_ADDU;
			cpu_pkg::OPC_SLTI:  op_o = cpu_pkg::OP_SLT;
			cpu_pkg::OPC_SLTIU: op_o = cpu_pkg::OP_SLTU;
			cpu_pkg::OPC_LW:    op_o = cpu_pkg::OP_LW;
			cpu_pkg::OPC_ANDI: begin
				op_o           = cpu_pkg::OP_AND;
				unsigned_imm_o = 1'b1;
			end
			cpu_pkg::OPC_ORI: begin
				op_o           = cpu_pkg::OP_OR;
				unsigned_imm_o = 1'b1;
			end
			cpu_pkg::OPC_XORI: begin
				op_o           = cpu_pkg::OP_XOR;
				unsigned_imm_o = 1'b1;
			end
			cpu_pkg::OPC_LUI: begin
				// no register source
				op_o           = cpu_pkg::OP_LUI;
				reg_raddr1_o   = 5'd0;
				unsigned_imm_o = 1'b1;
			end
			cpu_pkg::OPC_SW, cpu_pkg::OPC_BEQ, cpu_pkg::OPC_BNE: begin
				op_o         = (opcode_i == cpu_pkg::OPC_SW)  ? cpu_pkg::OP_SW :
				               (opcode_i == cpu_pkg::OPC_BEQ) ? cpu_pkg::OP_BEQ :
				                                                cpu_pkg::OP_BNE;
				reg_raddr2_o = rt;
				reg_waddr_o  = 5'd0;
				reg_we_o     = 1'b0;
			end
			cpu_pkg::OPC_REGIMM: begin
				// rt selects the branch, not a register
				reg_waddr_o = 5'd0;
				reg_we_o    = 1'b0;
				if (rt == cpu_pkg::RT_BLTZ) begin
					op_o = cpu_pkg::OP_BLTZ;
				end else if (rt == cpu_pkg::RT_BGEZ) begin
					op_o = cpu_pkg::OP_BGEZ;
				end
			end
			default: begin
				reg_raddr1_o = 5'd0;
				reg_waddr_o  = 5'd0;
				reg_we_o     = 1'b0;
			end
		endcase

		if (op_o == cpu_pkg::OP_INVALID) begin
			reg_raddr1_o = 5'd0;
			reg_we_o     = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/id_type_r.sv ====
`default_nettype none

module id_type_r (
	input  wire logic [5:0]         opcode_i,
	input  wire cpu_pkg::inst_t     inst_i,
	output cpu_pkg::oper_e          op_o,
	output cpu_pkg::reg_addr_t      reg_raddr1_o,
	output cpu_pkg::reg_addr_t      reg_raddr2_o,
	output cpu_pkg::reg_addr_t      reg_waddr_o,
	output logic                    reg_we_o
);

	cpu_pkg::reg_addr_t rs, rt, rd;
	logic [5:0] funct;

	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign funct = inst_i[5:0];

	always_comb begin
		// three-register form unless funct says otherwise
		op_o         = cpu_pkg::OP_INVALID;
		reg_raddr1_o = rs;
		reg_raddr2_o = rt;
		reg_waddr_o  = rd;
		reg_we_o     = 1'b1;

		if (opcode_i == cpu_pkg::OPC_SPECIAL) begin
			case (funct)
				cpu_pkg::FN_ADDU: op_o = cpu_pkg::OP_ADDU;
				cpu_pkg::FN_SUBU: op_o = cpu_pkg::OP_SUBU;
				cpu_pkg::FN_AND:  op_o = cpu_pkg::OP_AND;
				cpu_pkg::FN_OR:   op_o = cpu_pkg::OP_OR;
				cpu_pkg::FN_XOR:  op_o = cpu_pkg::OP_XOR;
				cpu_pkg::FN_NOR:  op_o = cpu_pkg::OP_NOR;
				cpu_pkg::FN_SLT:  op_o = cpu_pkg::OP_SLT;
				cpu_pkg::FN_SLTU: op_o = cpu_pkg::OP_SLTU;
				cpu_pkg::FN_MOVZ: op_o = cpu_pkg::OP_MOVZ;
				cpu_pkg::FN_MOVN: op_o = cpu_pkg::OP_MOVN;
				cpu_pkg::FN_SLL, cpu_pkg::FN_SRL, cpu_pkg::FN_SRA: begin
					// shift amount comes from sa, so only rt is read
					op_o         = (funct == cpu_pkg::FN_SLL) ? cpu_pkg::OP_SLL :
					               (funct == cpu_pkg::FN_SRL) ? cpu_pkg::OP_SRL :
					                                            cpu_pkg::OP_SRA;
					reg_raddr1_o = 5'd0;
				end
				cpu_pkg::FN_JR: begin
					op_o         = cpu_pkg::OP_JR;
					reg_raddr2_o = 5'd0;
					reg_waddr_o  = 5'd0;
					reg_we_o     = 1'b0;
				end
				default: begin
					op_o = cpu_pkg::OP_INVALID;
				end
			endcase
		end

		// unknown funct or not special at all
		if (op_o == cpu_pkg::OP_INVALID) begin
			reg_raddr1_o = 5'd0;
			reg_raddr2_o = 5'd0;
			reg_waddr_o  = 5'd0;
			reg_we_o     = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`default_nettype none

module regfile (
	input  wire logic                    clk_i,
	input  wire logic                    rst_n_i,
	input  wire cpu_pkg::reg_addr_t      raddr1_i,
	input  wire cpu_pkg::reg_addr_t      raddr2_i,
	output cpu_pkg::word_t               rdata1_o,
	output cpu_pkg::word_t               rdata2_o,
	input  wire cpu_pkg::reg_write_req_t wr_i
);

	// entry 0 is never written, so it stays zero
	cpu_pkg::word_t regs [32];

	// same-cycle write is visible to the read
	function automatic cpu_pkg::word_t read_port(
		input cpu_pkg::reg_addr_t      raddr,
		input cpu_pkg::word_t          stored,
		input cpu_pkg::reg_write_req_t wr
	);
		cpu_pkg::word_t data;
		data = stored;
		if (raddr != 5'd0 && wr.we && wr.waddr == raddr) begin
			data = wr.wdata;
		end
		return data;
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= cpu_pkg::ZERO_WORD;
			end
		end else if (wr_i.we && wr_i.waddr != 5'd0) begin
			regs[wr_i.waddr] <= wr_i.wdata;
		end
	end

	assign rdata1_o = read_port(raddr1_i, regs[raddr1_i], wr_i);
	assign rdata2_o = read_port(raddr2_i, regs[raddr2_i], wr_i);

endmodule

`default_nettype wire

// ==== verif/tb_cpu_id.sv ====
`default_nettype none

module tb_cpu_id;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 20;
	// about 65 cycles of stimulus, rounded up
	localparam int TEST_CYCLES = 70;
	localparam int TIMEOUT_NS  = (TEST_CYCLES + 30) * CLK_PERIOD;

	logic clk_i;
	logic rst_n_i;
	cpu_pkg::inst_addr_t      pc_i;
	cpu_pkg::inst_t           inst_i;
	logic                     delayslot_i;
	cpu_pkg::mem_access_req_t ex_mem_req_i;
	cpu_pkg::reg_write_req_t  ex_wr_i;
	cpu_pkg::reg_write_req_t  mem_wr_i;
	cpu_pkg::reg_write_req_t  wb_wr_i;
	cpu_pkg::pipeline_data_t  id_ex_o;
	logic                     id_ex_valid_o;
	logic                     stall_o;

	// what the register file should hold after wb writes
	cpu_pkg::word_t shadow [32];
	int errors;
	int checks;
	int seed;

	cpu_id_top i_dut (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.pc_i          (pc_i),
		.inst_i        (inst_i),
		.delayslot_i   (delayslot_i),
		.ex_mem_req_i  (ex_mem_req_i),
		.ex_wr_i       (ex_wr_i),
		.mem_wr_i      (mem_wr_i),
		.wb_wr_i       (wb_wr_i),
		.id_ex_o       (id_ex_o),
		.id_ex_valid_o (id_ex_valid_o),
		.stall_o       (stall_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	function automatic cpu_pkg::inst_t r_inst(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] funct);
		return {cpu_pkg::OPC_SPECIAL, rs, rt, rd, sa, funct};
	endfunction

	function automatic cpu_pkg::inst_t i_inst(input logic [5:0] opc, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// drives the next instruction and lets decode settle
	task automatic apply(input cpu_pkg::inst_t inst);
		inst_i = inst;
		pc_i   = pc_i + 32'd4;
		#1;
	endtask

	task automatic advance();
		@(posedge clk_i);
		@(negedge clk_i);
	endtask

	task automatic issue(input cpu_pkg::inst_t inst);
		apply(inst);
		advance();
	endtask

	task automatic write_reg(input cpu_pkg::reg_addr_t addr, input cpu_pkg::word_t data);
		wb_wr_i = {1'b1, addr, data};
		advance();
		wb_wr_i = '0;
		if (addr != 5'd0) begin
			shadow[addr] = data;
		end
	endtask

	task automatic verify_decode(input cpu_pkg::oper_e op, input cpu_pkg::reg_addr_t raddr1,
			input cpu_pkg::reg_addr_t raddr2, input logic we,
			input cpu_pkg::reg_addr_t waddr, input string name);
		check(32'(id_ex_valid_o), 32'(1'b1), {name, " valid"});
		check(32'(id_ex_o.op), 32'(op), {name, " op"});
		check(32'(id_ex_o.reg_raddr1), 32'(raddr1), {name, " reg_raddr1"});
		check(32'(id_ex_o.reg_raddr2), 32'(raddr2), {name, " reg_raddr2"});
		check(32'(id_ex_o.reg_we), 32'(we), {name, " reg_we"});
		// waddr has no meaning without a write
		if (we) begin
			check(32'(id_ex_o.reg_waddr), 32'(waddr), {name, " reg_waddr"});
		end
		check(id_ex_o.pc, pc_i, {name, " pc"});
		check(id_ex_o.inst, inst_i, {name, " inst"});
	endtask

	task automatic compare_operands(input cpu_pkg::word_t reg1, input cpu_pkg::word_t reg2,
			input string name);
		check(id_ex_o.reg1, reg1, {name, " reg1"});
		check(id_ex_o.reg2, reg2, {name, " reg2"});
	endtask

	task automatic rtype_ops();
		check(32'(id_ex_valid_o), 32'(1'b0), "valid after reset");
		check(32'(stall_o), 32'(1'b0), "stall after reset");
		check(32'(id_ex_o.reg_we), 32'(1'b0), "reg_we after reset");
		for (int r = 1; r < 32; r++) begin
			write_reg(5'(r), $random(seed));
		end
		issue(r_inst(5'd5, 5'd9, 5'd12, 5'd0, cpu_pkg::FN_ADDU));
		verify_decode(cpu_pkg::OP_ADDU, 5'd5, 5'd9, 1'b1, 5'd12, "addu");
		compare_operands(shadow[5], shadow[9], "addu");
		// rs is r0
		issue(r_inst(5'd0, 5'd17, 5'd2, 5'd0, cpu_pkg::FN_SUBU));
		verify_decode(cpu_pkg::OP_SUBU, 5'd0, 5'd17, 1'b1, 5'd2, "subu");
		compare_operands(32'h0, shadow[17], "subu");
		// rs field set but a shift reads only rt
		issue(r_inst(5'd8, 5'd7, 5'd3, 5'd4, cpu_pkg::FN_SRA));
		verify_decode(cpu_pkg::OP_SRA, 5'd0, 5'd7, 1'b1, 5'd3, "sra");
		compare_operands(32'h0, shadow[7], "sra");
	endtask

	task automatic itype_ops();
		issue(i_inst(cpu_pkg::OPC_ORI, 5'd4, 5'd6, 16'h8001));
		verify_decode(cpu_pkg::OP_OR, 5'd4, 5'd0, 1'b1, 5'd6, "ori");
		check(id_ex_o.imm, 32'h0000_8001, "ori imm");
		compare_operands(shadow[4], 32'h0000_8001, "ori");
		issue(i_inst(cpu_pkg::OPC_ANDI, 5'd7, 5'd13, 16'hf0f0));
		verify_decode(cpu_pkg::OP_AND, 5'd7, 5'd0, 1'b1, 5'd13, "andi");
		compare_operands(shadow[7], 32'h0000_f0f0, "andi");
		issue(i_inst(cpu_pkg::OPC_ADDIU, 5'd3, 5'd11, 16'hfff0));
		verify_decode(cpu_pkg::OP_ADDU, 5'd3, 5'd0, 1'b1, 5'd11, "addiu");
		check(id_ex_o.imm, 32'hffff_fff0, "addiu imm");
		compare_operands(shadow[3], 32'hffff_fff0, "addiu");
		issue(i_inst(cpu_pkg::OPC_LW, 5'd2, 5'd8, 16'h8004));
		verify_decode(cpu_pkg::OP_LW, 5'd2, 5'd0, 1'b1, 5'd8, "lw");
		compare_operands(shadow[2], 32'hffff_8004, "lw");
		// stores and branches take rt as the second operand
		issue(i_inst(cpu_pkg::OPC_SW, 5'd2, 5'd9, 16'h0004));
		verify_decode(cpu_pkg::OP_SW, 5'd2, 5'd9, 1'b0, 5'd0, "sw");
		compare_operands(shadow[2], shadow[9], "sw");
		issue(i_inst(cpu_pkg::OPC_BEQ, 5'd1, 5'd2, 16'hfffc));
		verify_decode(cpu_pkg::OP_BEQ, 5'd1, 5'd2, 1'b0, 5'd0, "beq");
		compare_operands(shadow[1], shadow[2], "beq");
		// lui ignores its rs field
		issue(i_inst(cpu_pkg::OPC_LUI, 5'd14, 5'd10, 16'h1234));
		verify_decode(cpu_pkg::OP_LUI, 5'd0, 5'd0, 1'b1, 5'd10, "lui");
		check(id_ex_o.imm, 32'h0000_1234, "lui imm");
		compare_operands(32'h0, 32'h0000_1234, "lui");
	endtask

	task automatic jump_ops();
		issue({cpu_pkg::OPC_JAL, 26'h3123456});
		verify_decode(cpu_pkg::OP_JAL, 5'd0, 5'd0, 1'b1, 5'd31, "jal");
		delayslot_i = 1'b1;
		issue(r_inst(5'd1, 5'd2, 5'd3, 5'd0, cpu_pkg::FN_OR));
		check(32'(id_ex_o.delayslot), 32'(1'b1), "delay slot flag");
		delayslot_i = 1'b0;
		issue({cpu_pkg::OPC_J, 26'h2a50040});
		verify_decode(cpu_pkg::OP_J, 5'd0, 5'd0, 1'b0, 5'd0, "j");
		check(32'(id_ex_o.delayslot), 32'(1'b0), "j delay slot flag");
		issue({6'b111111, 26'h3ffffff});
		verify_decode(cpu_pkg::OP_INVALID, 5'd0, 5'd0, 1'b0, 5'd0, "undefined opcode");
	endtask

	task automatic operand_forwarding();
		cpu_pkg::word_t wb_data;
		// EX beats MEM on the same register
		ex_wr_i  = {1'b1, 5'd5, 32'h1111_aaaa};
		mem_wr_i = {1'b1, 5'd5, 32'h2222_bbbb};
		issue(r_inst(5'd5, 5'd6, 5'd7, 5'd0, cpu_pkg::FN_ADDU));
		compare_operands(32'h1111_aaaa, shadow[6], "ex over mem");
		// disabled EX request is ignored and MEM feeds rt
		ex_wr_i  = {1'b0, 5'd5, 32'h1111_aaaa};
		mem_wr_i = {1'b1, 5'd6, 32'h3333_cccc};
		issue(r_inst(5'd5, 5'd6, 5'd7, 5'd0, cpu_pkg::FN_ADDU));
		compare_operands(shadow[5], 32'h3333_cccc, "mem over regfile");
		// r0 is never forwarded
		ex_wr_i  = {1'b1, 5'd0, 32'h4444_dddd};
		mem_wr_i = {1'b0, 5'd6, 32'h3333_cccc};
		issue(r_inst(5'd0, 5'd6, 5'd7, 5'd0, cpu_pkg::FN_ADDU));
		compare_operands(32'h0, shadow[6], "r0 and disabled mem");
		ex_wr_i  = '0;
		mem_wr_i = '0;
		// writeback in the same cycle as the read
		wb_data = $random(seed);
		wb_wr_i = {1'b1, 5'd6, wb_data};
		issue(r_inst(5'd5, 5'd6, 5'd7, 5'd0, cpu_pkg::FN_ADDU));
		wb_wr_i   = '0;
		shadow[6] = wb_data;
		compare_operands(shadow[5], wb_data, "same cycle writeback");
	endtask

	task automatic cond_move();
		write_reg(5'd20, 32'h0);
		write_reg(5'd21, $random(seed) | 32'h1);
		issue(r_inst(5'd3, 5'd20, 5'd4, 5'd0, cpu_pkg::FN_MOVN));
		verify_decode(cpu_pkg::OP_MOVN, 5'd3, 5'd20, 1'b0, 5'd4, "movn zero");
		issue(r_inst(5'd3, 5'd21, 5'd4, 5'd0, cpu_pkg::FN_MOVN));
		verify_decode(cpu_pkg::OP_MOVN, 5'd3, 5'd21, 1'b1, 5'd4, "movn nonzero");
		issue(r_inst(5'd3, 5'd20, 5'd4, 5'd0, cpu_pkg::FN_MOVZ));
		verify_decode(cpu_pkg::OP_MOVZ, 5'd3, 5'd20, 1'b1, 5'd4, "movz zero");
		issue(r_inst(5'd3, 5'd21, 5'd4, 5'd0, cpu_pkg::FN_MOVZ));
		verify_decode(cpu_pkg::OP_MOVZ, 5'd3, 5'd21, 1'b0, 5'd4, "movz nonzero");
	endtask

	task automatic load_use_stall();
		// load in EX targets r6, which the add reads
		ex_mem_req_i = 2'b10;
		ex_wr_i      = {1'b1, 5'd6, 32'h0};
		apply(r_inst(5'd5, 5'd6, 5'd7, 5'd0, cpu_pkg::FN_ADDU));
		check(32'(stall_o), 32'(1'b1), "stall on load-use");
		advance();
		check(32'(id_ex_valid_o), 32'(1'b0), "bubble valid");
		check(32'(id_ex_o.reg_we), 32'(1'b0), "bubble reg_we");
		check(32'(id_ex_o.op), 32'(cpu_pkg::OP_INVALID), "bubble op");
		// load moves on to MEM while the add stays held
		ex_mem_req_i = '0;
		ex_wr_i      = '0;
		mem_wr_i     = {1'b1, 5'd6, 32'h5555_eeee};
		#1;
		check(32'(stall_o), 32'(1'b0), "stall released");
		advance();
		verify_decode(cpu_pkg::OP_ADDU, 5'd5, 5'd6, 1'b1, 5'd7, "held addu");
		compare_operands(shadow[5], 32'h5555_eeee, "held addu");
		mem_wr_i = '0;
		ex_mem_req_i = 2'b11;
		ex_wr_i      = {1'b0, 5'd6, 32'h0};
		issue(r_inst(5'd5, 5'd6, 5'd7, 5'd0, cpu_pkg::FN_ADDU));
		check(32'(id_ex_valid_o), 32'(1'b1), "no stall on store");
		ex_mem_req_i = 2'b10;
		ex_wr_i      = {1'b1, 5'd0, 32'h0};
		apply(r_inst(5'd0, 5'd9, 5'd7, 5'd0, cpu_pkg::FN_ADDU));
		check(32'(stall_o), 32'(1'b0), "no stall on r0 match");
		advance();
		// sll does not read rs
		ex_wr_i = {1'b1, 5'd6, 32'h0};
		apply(r_inst(5'd6, 5'd9, 5'd7, 5'd2, cpu_pkg::FN_SLL));
		check(32'(stall_o), 32'(1'b0), "no stall on unread rs");
		advance();
		ex_mem_req_i = '0;
		ex_wr_i      = '0;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		seed         = 32'h269d;
		errors       = 0;
		checks       = 0;
		clk_i        = 1'b0;
		rst_n_i      = 1'b0;
		pc_i         = 32'h0000_1000;
		inst_i       = '0;
		delayslot_i  = 1'b0;
		ex_mem_req_i = '0;
		ex_wr_i      = '0;
		mem_wr_i     = '0;
		wb_wr_i      = '0;
		for (int r = 0; r < 32; r++) begin
			shadow[r] = 32'h0;
		end
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;

		rtype_ops();
		itype_ops();
		jump_ops();
		operand_forwarding();
		cond_move();
		load_use_stall();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
